// ==== compy_video.f ====
src/compy_pkg.sv
src/video_memory.sv
src/fetch_sequencer.sv
src/fetch_buffer.sv
src/pixel_serializer.sv
src/compy_video.sv
testbench/compy_video_chk.sv
testbench/tb_compy_video.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compy_video.f \
   --top-module tb_compy_video -o tb_compy_video &&
obj_dir/tb_compy_video | tee /dev/stderr | grep -q "^TEST OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== src/compy_pkg.sv ====
package compy_pkg;

   localparam int VRAM_ADDR_W  = 8;      // 256 byte video memory
   localparam int FRAME_BYTES  = 16;     // bytes per frame
   localparam int FIFO_DEPTH   = 8;      // buffer entries, also initial credits
   localparam int CREDIT_W     = 4;      // holds 0..FIFO_DEPTH
   localparam int READ_LATENCY = 2;      // rd_req to rd_ack cycles

   localparam int FRAME_CNT_W  = $clog2(FRAME_BYTES + 1);
   localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

   typedef enum logic [1:0] {
      CMD_WRITE_VRAM,
      CMD_SET_COLOR,
      CMD_START_FRAME
   } host_op_e;

   typedef enum logic [1:0] {
      IDLE,
      FETCH,
      DRAIN
   } fetch_state_e;

   // same split as the vga_r / vga_g / vga_b pins
   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb565_t;

   localparam rgb565_t COLOR_WHITE = '{r: 5'h1f, g: 6'h3f, b: 5'h1f};
   localparam rgb565_t COLOR_BLACK = '{r: 5'h00, g: 6'h00, b: 5'h00};

   typedef struct packed {
      host_op_e               op;
      logic [VRAM_ADDR_W-1:0] addr;   // write address or frame start offset
      logic [7:0]             data;   // byte for CMD_WRITE_VRAM
      rgb565_t                fg;
      rgb565_t                bg;
   } host_cmd_t;

   typedef struct packed {
      rgb565_t color;
      logic    last;                  // final pixel of the frame
   } pixel_t;

   typedef struct packed {
      logic [7:0] data;
      logic       last;               // final byte of the frame
   } fetch_beat_t;

endpackage

// ==== src/compy_video.sv ====
`timescale 1ns/1ps

module compy_video (
   input  logic                 sys_clk,
   input  logic                 reset_n,
   input  logic                 host_valid,
   input  compy_pkg::host_cmd_t host_cmd,
   output logic                 host_ready,
   output logic                 pixel_valid,
   output compy_pkg::pixel_t    pixel,
   input  logic                 pixel_ready
);
   import compy_pkg::*;

   logic                   wr_en;
   logic [VRAM_ADDR_W-1:0] wr_addr;
   logic [7:0]             wr_data;
   logic                   rd_req;
   logic [VRAM_ADDR_W-1:0] rd_addr;
   logic                   rd_ack;
   logic [7:0]             rd_data;
   logic                   push;
   fetch_beat_t            push_beat;
   logic                   credit_return;
   logic                   beat_valid;
   fetch_beat_t            beat;
   logic                   pop;
   logic                   frame_end;

   fetch_sequencer fetch_sequencer_inst (
      .sys_clk       (sys_clk),
      .reset_n       (reset_n),
      .host_valid    (host_valid),
      .host_cmd      (host_cmd),
      .host_ready    (host_ready),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .rd_req        (rd_req),
      .rd_addr       (rd_addr),
      .rd_ack        (rd_ack),
      .rd_data       (rd_data),
      .push          (push),
      .push_beat     (push_beat),
      .credit_return (credit_return),
      .frame_end     (frame_end)
   );

   video_memory video_memory_inst (
      .sys_clk (sys_clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_req  (rd_req),
      .rd_addr (rd_addr),
      .rd_ack  (rd_ack),
      .rd_data (rd_data)
   );

   fetch_buffer fetch_buffer_inst (
      .sys_clk       (sys_clk),
      .reset_n       (reset_n),
      .push          (push),
      .push_beat     (push_beat),
      .beat_valid    (beat_valid),
      .beat          (beat),
      .pop           (pop),
      .credit_return (credit_return)
   );

   pixel_serializer pixel_serializer_inst (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .host_valid  (host_valid),
      .host_ready  (host_ready),
      .host_cmd    (host_cmd),
      .beat_valid  (beat_valid),
      .beat        (beat),
      .pop         (pop),
      .pixel_valid (pixel_valid),
      .pixel       (pixel),
      .pixel_ready (pixel_ready),
      .frame_end   (frame_end)
   );

endmodule

// ==== src/fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic                   push,
   input  compy_pkg::fetch_beat_t push_beat,
   output logic                   beat_valid,
   output compy_pkg::fetch_beat_t beat,
   input  logic                   pop,
   output logic                   credit_return
);
   import compy_pkg::*;

   fetch_beat_t           mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [CREDIT_W-1:0]   count;
   logic                  do_pop;

   assign beat_valid = (count != '0);
   assign beat       = mem[rd_ptr];            // head is always visible
   assign do_pop     = pop && beat_valid;

   // space is reserved by the sender's credits, so push is never refused
   always_ff @(posedge sys_clk) begin
      if (push) begin
         mem[wr_ptr] <= push_beat;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         count <= '0;
      end else begin
         count <= count + CREDIT_W'(push) - CREDIT_W'(do_pop);
      end
   end

   // one credit back per popped entry
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         credit_return <= 1'b0;
      end else begin
         credit_return <= do_pop;
      end
   end

endmodule

// ==== src/fetch_sequencer.sv ====
`timescale 1ns/1ps

module fetch_sequencer (
   input  logic                               sys_clk,
   input  logic                               reset_n,
   input  logic                               host_valid,
   input  compy_pkg::host_cmd_t               host_cmd,
   output logic                               host_ready,
   output logic                               wr_en,
   output logic [compy_pkg::VRAM_ADDR_W-1:0]  wr_addr,
   output logic [7:0]                         wr_data,
   output logic                               rd_req,
   output logic [compy_pkg::VRAM_ADDR_W-1:0]  rd_addr,
   input  logic                               rd_ack,
   input  logic [7:0]                         rd_data,
   output logic                               push,
   output compy_pkg::fetch_beat_t             push_beat,
   input  logic                               credit_return,
   input  logic                               frame_end
);
   import compy_pkg::*;

   fetch_state_e           state;
   logic [CREDIT_W-1:0]    credits;
   logic [FRAME_CNT_W-1:0] req_cnt;
   logic [FRAME_CNT_W-1:0] ack_cnt;
   logic                   host_take;
   logic                   last_ack;

   assign host_ready = (state == IDLE);        // busy for the whole frame
   assign host_take  = host_valid && host_ready;

   // one read per cycle while bytes remain and buffer space is reserved
   assign rd_req = (state == FETCH)
                && (req_cnt < FRAME_CNT_W'(FRAME_BYTES))
                && (credits != '0);

   assign last_ack = (ack_cnt == FRAME_CNT_W'(FRAME_BYTES - 1));
   assign push     = rd_ack && (state == FETCH);

   always_comb begin
      push_beat.data = rd_data;
      push_beat.last = last_ack;               // tagged by ack count
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         credits <= CREDIT_W'(FIFO_DEPTH);
      end else begin
         credits <= credits - CREDIT_W'(rd_req) + CREDIT_W'(credit_return);
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state   <= IDLE;
         req_cnt <= '0;
         ack_cnt <= '0;
         wr_en   <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         case (state)
            IDLE: begin
               if (host_take) begin
                  case (host_cmd.op)
                     CMD_WRITE_VRAM: wr_en <= 1'b1;
                     CMD_START_FRAME: begin
                        state   <= FETCH;
                        req_cnt <= '0;
                        ack_cnt <= '0;
                     end
                     default: ;                // colors belong to the serializer
                  endcase
               end
            end
            FETCH: begin
               if (rd_req) begin
                  req_cnt <= req_cnt + 1'b1;
               end
               if (rd_ack) begin
                  ack_cnt <= ack_cnt + 1'b1;
                  if (last_ack) begin
                     state <= DRAIN;           // all bytes are in the buffer
                  end
               end
            end
            DRAIN: begin
               if (frame_end) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (host_take && host_cmd.op == CMD_WRITE_VRAM) begin
         wr_addr <= host_cmd.addr;
         wr_data <= host_cmd.data;
      end
      if (host_take && host_cmd.op == CMD_START_FRAME) begin
         rd_addr <= host_cmd.addr;
      end else if (rd_req) begin
         rd_addr <= rd_addr + 1'b1;            // wraps at 256
      end
   end

endmodule

// ==== src/pixel_serializer.sv ====
`timescale 1ns/1ps

module pixel_serializer (
   input  logic                   sys_clk,
   input  logic                   reset_n,
   input  logic                   host_valid,
   input  logic                   host_ready,
   input  compy_pkg::host_cmd_t   host_cmd,
   input  logic                   beat_valid,
   input  compy_pkg::fetch_beat_t beat,
   output logic                   pop,
   output logic                   pixel_valid,
   output compy_pkg::pixel_t      pixel,
   input  logic                   pixel_ready,
   output logic                   frame_end
);
   import compy_pkg::*;

   rgb565_t    fg;
   rgb565_t    bg;
   logic [7:0] shreg;
   logic [3:0] bits_left;                      // pixels still to send from shreg
   logic       last_beat;
   logic       fire;
   logic       emptying;

   assign pixel_valid = (bits_left != 4'd0);
   assign fire        = pixel_valid && pixel_ready;

   // refill on the cycle the final bit leaves, no bubble between bytes
   assign emptying = (bits_left == 4'd0) || ((bits_left == 4'd1) && fire);
   assign pop      = beat_valid && emptying;

   always_comb begin
      pixel.color = shreg[7] ? fg : bg;        // msb first
      pixel.last  = last_beat && (bits_left == 4'd1);
   end

   assign frame_end = fire && pixel.last;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         fg <= COLOR_WHITE;
         bg <= COLOR_BLACK;
      end else if (host_valid && host_ready && host_cmd.op == CMD_SET_COLOR) begin
         fg <= host_cmd.fg;
         bg <= host_cmd.bg;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         bits_left <= 4'd0;
      end else if (pop) begin
         bits_left <= 4'd8;
      end else if (fire) begin
         bits_left <= bits_left - 4'd1;
      end
   end

   // held while pixel_ready is low
   always_ff @(posedge sys_clk) begin
      if (pop) begin
         shreg     <= beat.data;
         last_beat <= beat.last;
      end else if (fire) begin
         shreg <= {shreg[6:0], 1'b0};
      end
   end

endmodule

// ==== src/video_memory.sv ====
`timescale 1ns/1ps

module video_memory (
   input  logic                               sys_clk,
   input  logic                               wr_en,
   input  logic [compy_pkg::VRAM_ADDR_W-1:0]  wr_addr,
   input  logic [7:0]                         wr_data,
   input  logic                               rd_req,
   input  logic [compy_pkg::VRAM_ADDR_W-1:0]  rd_addr,
   output logic                               rd_ack,
   output logic [7:0]                         rd_data
);
   import compy_pkg::*;

   logic [7:0]              mem [2**VRAM_ADDR_W];
   logic [READ_LATENCY-1:0] ack_pipe;
   logic [7:0]              data_pipe [READ_LATENCY];

   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // two stage read, like the req / req2 steps of the bus
   always_ff @(posedge sys_clk) begin
      ack_pipe[0] <= rd_req;
      if (rd_req) begin
         data_pipe[0] <= mem[rd_addr];           // old data on same-edge write
      end
      for (int i = 1; i < READ_LATENCY; i++) begin
         ack_pipe[i]  <= ack_pipe[i-1];
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   assign rd_ack  = ack_pipe[READ_LATENCY-1];
   assign rd_data = data_pipe[READ_LATENCY-1];

endmodule

// ==== testbench/compy_video_chk.sv ====
`timescale 1ns/1ps

module compy_video_chk (
   input logic                           sys_clk,
   input logic                           reset_n,
   input logic [compy_pkg::CREDIT_W-1:0] credits,
   input logic [compy_pkg::CREDIT_W-1:0] fifo_count,
   input logic                           push,
   input logic                           pixel_valid,
   input logic                           pixel_ready,
   input compy_pkg::pixel_t              pixel
);
   import compy_pkg::*;

   credit_limit: assert property (@(posedge sys_clk) disable iff (!reset_n)
      credits <= CREDIT_W'(FIFO_DEPTH))
      else $error("credit counter above buffer depth");

   // credits reserve a slot for every read in flight
   no_push_when_full: assert property (@(posedge sys_clk) disable iff (!reset_n)
      push |-> (fifo_count < CREDIT_W'(FIFO_DEPTH)))
      else $error("push into a full fetch buffer");

   pixel_held: assert property (@(posedge sys_clk) disable iff (!reset_n)
      (pixel_valid && !pixel_ready) |=> (pixel_valid && $stable(pixel)))
      else $error("pixel changed while stalled");

endmodule

bind compy_video compy_video_chk compy_video_chk_inst (
   .sys_clk     (sys_clk),
   .reset_n     (reset_n),
   .credits     (fetch_sequencer_inst.credits),
   .fifo_count  (fetch_buffer_inst.count),
   .push        (push),
   .pixel_valid (pixel_valid),
   .pixel_ready (pixel_ready),
   .pixel       (pixel)
);

// ==== testbench/tb_compy_video.sv ====
`timescale 1ns/1ps

module tb_compy_video;
   import compy_pkg::*;

   localparam int FRAME_PIXELS = FRAME_BYTES * 8;
   localparam int CYCLE_LIMIT  = 20000;        // fill plus six frames need about 2000

   logic        sys_clk;
   logic        reset_n;
   logic        host_valid;
   host_cmd_t   host_cmd;
   logic        host_ready;
   logic        pixel_valid;
   pixel_t      pixel;
   logic        pixel_ready;

   logic [7:0]  vram_model [256];
   rgb565_t     fg_model;
   rgb565_t     bg_model;
   integer      seed;
   logic [31:0] rnd;
   logic [7:0]  frame_offset;
   int          cycle_cnt = 0;
   int          err_cnt;
   int          test_start_errs;
   int          tests_passed;
   int          tests_failed;
   int          cmd_wait;

   compy_video compy_video_inst (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .host_valid  (host_valid),
      .host_cmd    (host_cmd),
      .host_ready  (host_ready),
      .pixel_valid (pixel_valid),
      .pixel       (pixel),
      .pixel_ready (pixel_ready)
   );

   always #4 sys_clk = ~sys_clk;

   always @(posedge sys_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("simulation timed out after %0d cycles", cycle_cnt);
         $display("TEST FAILED");
         $finish;
      end
   end

   // enters on a falling edge and returns on the falling edge after the transfer
   task automatic send_cmd(input host_cmd_t cmd, output int waits);
      waits      = 0;
      host_cmd   = cmd;
      host_valid = 1'b1;
      while (!host_ready) begin
         @(negedge sys_clk);
         waits++;
      end
      @(negedge sys_clk);
      host_valid = 1'b0;
   endtask

   task automatic write_byte(input logic [7:0] addr, input logic [7:0] data);
      host_cmd_t cmd;
      int        waits;
      cmd      = '0;
      cmd.op   = CMD_WRITE_VRAM;
      cmd.addr = addr;
      cmd.data = data;
      send_cmd(cmd, waits);
      vram_model[addr] = data;
   endtask

   task automatic set_colors(input rgb565_t fg, input rgb565_t bg, output int waits);
      host_cmd_t cmd;
      cmd    = '0;
      cmd.op = CMD_SET_COLOR;
      cmd.fg = fg;
      cmd.bg = bg;
      send_cmd(cmd, waits);
      fg_model = fg;
      bg_model = bg;
   endtask

   function automatic rgb565_t random_color();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   task automatic run_frame(input logic [7:0] offset, input int ready_pct);
      host_cmd_t   cmd;
      int          waits;
      int          idx;
      logic [7:0]  byte_val;
      pixel_t      expected;
      logic [31:0] r;
      cmd      = '0;
      cmd.op   = CMD_START_FRAME;
      cmd.addr = offset;
      send_cmd(cmd, waits);
      idx = 0;
      while (idx < FRAME_PIXELS) begin
         r           = $random(seed);
         pixel_ready = (int'(r % 32'd100) < ready_pct);
         if (host_ready) begin
            $display("FAILED t=%0t: host_ready high during frame at pixel %0d", $realtime, idx);
            err_cnt++;
         end
         if (pixel_valid && pixel_ready) begin
            byte_val       = vram_model[(int'(offset) + idx / 8) % 256];   // wraps at 256
            expected.color = byte_val[7 - idx % 8] ? fg_model : bg_model;
            expected.last  = (idx == FRAME_PIXELS - 1);
            if (pixel !== expected) begin
               $display("FAILED t=%0t: pixel %0d at offset %0d expected %h got %h",
                        $realtime, idx, offset, expected, pixel);
               err_cnt++;
            end
            idx++;
         end
         @(negedge sys_clk);
      end
      pixel_ready = 1'b0;
      if (!host_ready || pixel_valid) begin
         $display("FAILED t=%0t: after last pixel host_ready %b pixel_valid %b",
                  $realtime, host_ready, pixel_valid);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input int num, input string name);
      if (err_cnt == test_start_errs) begin
         $display("test %0d %s: passed", num, name);
         tests_passed++;
      end else begin
         $display("test %0d %s: failed with %0d errors", num, name, err_cnt - test_start_errs);
         tests_failed++;
      end
      test_start_errs = err_cnt;
   endtask

   initial begin
      sys_clk         = 1'b0;
      reset_n         = 1'b0;
      host_valid      = 1'b0;
      host_cmd        = '0;
      pixel_ready     = 1'b0;
      seed            = 32'h8210_e2ca;
      err_cnt         = 0;
      test_start_errs = 0;
      tests_passed    = 0;
      tests_failed    = 0;
      fg_model        = COLOR_WHITE;
      bg_model        = COLOR_BLACK;
      repeat (10) @(negedge sys_clk);
      reset_n = 1'b1;
      @(negedge sys_clk);

      for (int a = 0; a < 256; a++) begin
         rnd = $random(seed);
         write_byte(8'(a), rnd[7:0]);
      end
      set_colors(random_color(), random_color(), cmd_wait);
      run_frame(8'd0, 100);
      finish_test(1, "full fill, frame at offset 0");

      run_frame(8'd248, 100);                  // bytes 248..255 then 0..7
      finish_test(2, "frame wrapping past offset 255");

      rnd = $random(seed);
      run_frame(rnd[7:0], 25);
      finish_test(3, "frame with 25 percent pixel_ready");

      set_colors(random_color(), random_color(), cmd_wait);
      rnd          = $random(seed);
      frame_offset = rnd[7:0];
      for (int n = 0; n < 24; n++) begin
         rnd = $random(seed);
         write_byte(frame_offset + 8'(rnd[11:8]), rnd[7:0]);   // inside the next frame
      end
      run_frame(frame_offset, 50);
      finish_test(4, "new colors and data");

      run_frame(8'd100, 60);
      set_colors(random_color(), random_color(), cmd_wait);
      if (cmd_wait != 0) begin
         $display("FAILED t=%0t: command after frame waited %0d cycles", $realtime, cmd_wait);
         err_cnt++;
      end
      write_byte(8'd101, 8'ha5);
      run_frame(8'd100, 100);
      finish_test(5, "host_ready around frame end");

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
